/* include/rtc_defs.svh */
`ifndef RTC_DEFS_SVH
`define RTC_DEFS_SVH

// Chip register addresses
`define RTC_ADDR_CTRL_B   8'h02
`define RTC_ADDR_MASK     8'h01
`define RTC_ADDR_ENABLE   8'h00
`define RTC_ADDR_SEC      8'h21
`define RTC_ADDR_MIN      8'h22
`define RTC_ADDR_HOUR     8'h23

// Setup values, written in this order
`define RTC_INIT_SET      8'h10
`define RTC_INIT_CLEAR    8'h00
`define RTC_INIT_MASK     8'h44
`define RTC_INIT_ENABLE   8'h08
`define RTC_INIT_HOUR     8'h0C

// Bus timing
`define RTC_PHASE_CYCLES  4
`define RTC_POLL_CYCLES   64

// Host register offsets
`define RTC_APB_CTRL      8'h00
`define RTC_APB_STATUS    8'h04
`define RTC_APB_TIME      8'h08

`endif

/* logic/rtc_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rtc_defs.svh"

module rtc_apb_regs
    import rtc_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        start,
    input  logic        ready,
    input  logic        busy,
    input  time_bcd_t   snapshot
);

    logic access;
    logic addr_hit;

    // Access phase of an APB transfer
    assign access = psel && penable;

    always_comb begin
        addr_hit = (paddr == `RTC_APB_CTRL) ||
                   (paddr == `RTC_APB_STATUS) ||
                   (paddr == `RTC_APB_TIME);
    end

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access && !addr_hit;

    ////////////////////////////////////////////////////////////////////////////
    // CTRL register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            start <= 1'b0;
        end else if (access && pwrite && paddr == `RTC_APB_CTRL) begin
            start <= pwdata[0];
        end
    end

    // Read mux; STATUS and TIME ignore writes
    always_comb begin
        prdata = '0;
        case (paddr)
            `RTC_APB_CTRL: begin
                prdata[0] = start;
            end
            `RTC_APB_STATUS: begin
                prdata[0] = ready;
                prdata[1] = busy;
            end
            `RTC_APB_TIME: begin
                prdata[23:0] = snapshot;
            end
            default: begin
                prdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/rtc_bus_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rtc_defs.svh"

module rtc_bus_engine
    import rtc_bus_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       abort,
    input  logic       init_valid,
    input  bus_req_t   init_req,
    output logic       init_done,
    input  logic       read_valid,
    input  bus_req_t   read_req,
    output logic       read_done,
    output logic [7:0] rdata,
    output rtc_pins_t  pins,
    input  logic [7:0] ad_in
);

    localparam int CNT_W = $clog2(`RTC_PHASE_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`RTC_PHASE_CYCLES - 1);

    bus_phase_e       phase;
    bus_phase_e       phase_next;
    logic [CNT_W-1:0] cnt;
    logic             phase_end;
    logic             grant_init;
    bus_req_t         req_q;
    logic             xfer_done;

    assign phase_end = (cnt == CNT_LAST);

    always_comb begin
        case (phase)
            PH_ADDR:  phase_next = PH_LATCH;
            PH_LATCH: phase_next = PH_DATA;
            PH_DATA:  phase_next = PH_END;
            default:  phase_next = PH_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Grant and phase sequencing
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset || abort) begin
            phase      <= PH_IDLE;
            cnt        <= '0;
            grant_init <= 1'b0;
        end else if (phase == PH_IDLE) begin
            cnt <= '0;
            if (init_valid || read_valid) begin
                // Init client wins a tie
                phase      <= PH_ADDR;
                grant_init <= init_valid;
            end
        end else if (phase_end) begin
            phase <= phase_next;
            cnt   <= '0;
        end else begin
            cnt <= cnt + CNT_W'(1);
        end
    end

    // Request and read data
    always_ff @(posedge clk) begin
        if (phase == PH_IDLE) begin
            req_q <= init_valid ? init_req : read_req;
        end
        if (phase == PH_DATA && phase_end && req_q.op == BUS_READ) begin
            rdata <= ad_in;
        end
    end

    // Done in the last cycle of the closing phase
    assign xfer_done = (phase == PH_END) && phase_end && !abort;
    assign init_done = xfer_done && grant_init;
    assign read_done = xfer_done && !grant_init;

    ////////////////////////////////////////////////////////////////////////////
    // Pin decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        pins.cs_n   = 1'b1;
        pins.as_sel = 1'b0;
        pins.rd_n   = 1'b1;
        pins.wr_n   = 1'b1;
        pins.ad_oe  = 1'b0;
        pins.ad_out = '0;
        case (phase)
            PH_ADDR: begin
                pins.cs_n   = 1'b0;
                pins.ad_oe  = 1'b1;
                pins.ad_out = req_q.addr;
            end
            PH_LATCH: begin
                pins.cs_n   = 1'b0;
                pins.wr_n   = 1'b0;
                pins.ad_oe  = 1'b1;
                pins.ad_out = req_q.addr;
            end
            PH_DATA: begin
                pins.cs_n   = 1'b0;
                pins.as_sel = 1'b1;
                if (req_q.op == BUS_WRITE) begin
                    pins.wr_n   = 1'b0;
                    pins.ad_oe  = 1'b1;
                    pins.ad_out = req_q.wdata;
                end else begin
                    // Bus released so the chip can drive
                    pins.rd_n = 1'b0;
                end
            end
            default: begin
                pins.cs_n = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/rtc_bus_pkg.sv */
`default_nettype none

package rtc_bus_pkg;

    // Direction of one chip access
    typedef enum logic [0:0] {
        BUS_WRITE = 1'b0,
        BUS_READ  = 1'b1
    } bus_op_e;

    // One client request, held steady until done
    typedef struct packed {
        bus_op_e    op;
        logic [7:0] addr;
        logic [7:0] wdata;
    } bus_req_t;

    // Chip pins as seen from the controller
    typedef struct packed {
        logic       cs_n;
        logic       as_sel;   // high in the data phase
        logic       rd_n;
        logic       wr_n;
        logic       ad_oe;
        logic [7:0] ad_out;
    } rtc_pins_t;

    // Bus engine phases
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_ADDR,
        PH_LATCH,
        PH_DATA,
        PH_END
    } bus_phase_e;

endpackage

`default_nettype wire

/* logic/rtc_controller_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rtc_controller_top
    import rtc_bus_pkg::*;
    import rtc_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output rtc_pins_t   rtc_pins,
    input  logic [7:0]  rtc_ad_in
);

    logic       start;
    logic       ready;
    logic       init_valid;
    bus_req_t   init_req;
    logic       init_done;
    logic       read_valid;
    bus_req_t   read_req;
    logic       read_done;
    logic [7:0] rdata;
    time_bcd_t  snapshot;

    ////////////////////////////////////////////////////////////////////////////
    // Host side
    ////////////////////////////////////////////////////////////////////////////
    rtc_apb_regs apb_regs_i (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .start    (start),
        .ready    (ready),
        .busy     (init_valid),
        .snapshot (snapshot)
    );

    // Bus clients
    rtc_init_sequencer init_seq_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .ready     (ready),
        .req_valid (init_valid),
        .req       (init_req),
        .done      (init_done)
    );

    rtc_time_reader time_reader_i (
        .clk       (clk),
        .reset     (reset),
        .ready     (ready),
        .req_valid (read_valid),
        .req       (read_req),
        .done      (read_done),
        .rdata     (rdata),
        .snapshot  (snapshot)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Chip side
    ////////////////////////////////////////////////////////////////////////////
    rtc_bus_engine bus_engine_i (
        .clk        (clk),
        .reset      (reset),
        .abort      (~start),
        .init_valid (init_valid),
        .init_req   (init_req),
        .init_done  (init_done),
        .read_valid (read_valid),
        .read_req   (read_req),
        .read_done  (read_done),
        .rdata      (rdata),
        .pins       (rtc_pins),
        .ad_in      (rtc_ad_in)
    );

endmodule

`default_nettype wire

/* logic/rtc_ctrl_pkg.sv */
`default_nettype none

package rtc_ctrl_pkg;

    // Init sequencer, one state per setup write
    typedef enum logic [2:0] {
        INIT_IDLE,
        INIT_SET,
        INIT_CLEAR,
        INIT_MASK,
        INIT_ENABLE,
        INIT_HOUR,
        INIT_DONE
    } init_state_e;

    // Time reader states
    typedef enum logic [2:0] {
        RD_IDLE,
        RD_WAIT,
        RD_SEC,
        RD_MIN,
        RD_HOUR,
        RD_PUBLISH
    } read_state_e;

    // Time of day, BCD
    typedef struct packed {
        logic [7:0] hour;
        logic [7:0] min;
        logic [7:0] sec;
    } time_bcd_t;

endpackage

`default_nettype wire

/* logic/rtc_init_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rtc_defs.svh"

module rtc_init_sequencer
    import rtc_bus_pkg::*;
    import rtc_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    output logic     ready,
    output logic     req_valid,
    output bus_req_t req,
    input  logic     done
);

    init_state_e state;
    init_state_e next_write;

    ////////////////////////////////////////////////////////////////////////////
    // Address and value of each setup write
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        req        = '0;
        req.op     = BUS_WRITE;
        next_write = INIT_IDLE;
        case (state)
            INIT_SET: begin
                req.addr   = `RTC_ADDR_CTRL_B;
                req.wdata  = `RTC_INIT_SET;
                next_write = INIT_CLEAR;
            end
            INIT_CLEAR: begin
                req.addr   = `RTC_ADDR_CTRL_B;
                req.wdata  = `RTC_INIT_CLEAR;
                next_write = INIT_MASK;
            end
            INIT_MASK: begin
                req.addr   = `RTC_ADDR_MASK;
                req.wdata  = `RTC_INIT_MASK;
                next_write = INIT_ENABLE;
            end
            INIT_ENABLE: begin
                req.addr   = `RTC_ADDR_ENABLE;
                req.wdata  = `RTC_INIT_ENABLE;
                next_write = INIT_HOUR;
            end
            INIT_HOUR: begin
                req.addr   = `RTC_ADDR_HOUR;
                req.wdata  = `RTC_INIT_HOUR;
                next_write = INIT_DONE;
            end
            default: begin
                next_write = INIT_IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // State walk, restarted whenever start falls
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset || !start) begin
            state     <= INIT_IDLE;
            req_valid <= 1'b0;
        end else begin
            case (state)
                INIT_IDLE: begin
                    state     <= INIT_SET;
                    req_valid <= 1'b0;
                end
                INIT_DONE: begin
                    req_valid <= 1'b0;
                end
                default: begin
                    // Drop valid for a cycle between writes
                    if (done) begin
                        state     <= next_write;
                        req_valid <= 1'b0;
                    end else begin
                        req_valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    assign ready = (state == INIT_DONE);

endmodule

`default_nettype wire

/* logic/rtc_time_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rtc_defs.svh"

module rtc_time_reader
    import rtc_bus_pkg::*;
    import rtc_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ready,
    output logic       req_valid,
    output bus_req_t   req,
    input  logic       done,
    input  logic [7:0] rdata,
    output time_bcd_t  snapshot
);

    localparam int POLL_W = $clog2(`RTC_POLL_CYCLES);
    localparam logic [POLL_W-1:0] POLL_LAST = POLL_W'(`RTC_POLL_CYCLES - 1);

    read_state_e       state;
    read_state_e       next_read;
    logic [POLL_W-1:0] poll_cnt;
    time_bcd_t         stage;

    // Register to read in each state
    always_comb begin
        req       = '0;
        req.op    = BUS_READ;
        next_read = RD_IDLE;
        case (state)
            RD_SEC: begin
                req.addr  = `RTC_ADDR_SEC;
                next_read = RD_MIN;
            end
            RD_MIN: begin
                req.addr  = `RTC_ADDR_MIN;
                next_read = RD_HOUR;
            end
            RD_HOUR: begin
                req.addr  = `RTC_ADDR_HOUR;
                next_read = RD_PUBLISH;
            end
            default: begin
                next_read = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || !ready) begin
            state     <= RD_IDLE;
            req_valid <= 1'b0;
            poll_cnt  <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    state    <= RD_WAIT;
                    poll_cnt <= '0;
                end
                RD_WAIT: begin
                    if (poll_cnt == POLL_LAST) begin
                        state    <= RD_SEC;
                        poll_cnt <= '0;
                    end else begin
                        poll_cnt <= poll_cnt + POLL_W'(1);
                    end
                end
                RD_PUBLISH: begin
                    state <= RD_WAIT;
                end
                default: begin
                    if (done) begin
                        state     <= next_read;
                        req_valid <= 1'b0;
                    end else begin
                        req_valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Staging so the host only ever sees a whole time
    always_ff @(posedge clk) begin
        if (done && state == RD_SEC) begin
            stage.sec <= rdata;
        end
        if (done && state == RD_MIN) begin
            stage.min <= rdata;
        end
        if (done && state == RD_HOUR) begin
            stage.hour <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            snapshot <= '0;
        end else if (state == RD_PUBLISH) begin
            snapshot <= stage;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module rtc_controller_tb -o rtc_sim

out=$(./obj_dir/rtc_sim)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

/* tb.f */
+incdir+include
logic/rtc_bus_pkg.sv
logic/rtc_ctrl_pkg.sv
logic/rtc_init_sequencer.sv
logic/rtc_time_reader.sv
logic/rtc_bus_engine.sv
logic/rtc_apb_regs.sv
logic/rtc_controller_top.sv
verification/rtc_chip_model.sv
verification/rtc_controller_tb.sv

/* verification/rtc_chip_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rtc_defs.svh"

module rtc_chip_model
    import rtc_bus_pkg::*;
(
    input  logic       clk,
    input  rtc_pins_t  pins,
    output logic [7:0] ad_in
);

    logic [7:0]  regs [256];
    logic [7:0]  addr_latch = 8'h00;
    logic [7:0]  set_hour;
    logic [7:0]  set_min;
    logic [7:0]  set_sec;
    int unsigned set_seq = 0;
    int unsigned seen_seq = 0;

    // Power-up contents then the preset time
    initial begin
        for (int i = 0; i < 256; i++) begin
            regs[i] <= 8'(i) ^ 8'hA5;
        end
        regs[`RTC_ADDR_SEC] <= 8'h30;
        regs[`RTC_ADDR_MIN] <= 8'h15;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pin decode
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        // Address phase with the write strobe latches the address
        if (!pins.cs_n && !pins.as_sel && !pins.wr_n) begin
            addr_latch <= pins.ad_out;
        end
        if (!pins.cs_n && pins.as_sel && !pins.wr_n && pins.ad_oe) begin
            regs[addr_latch] <= pins.ad_out;
        end
        // Time change requested by the testbench
        if (set_seq != seen_seq) begin
            regs[`RTC_ADDR_HOUR] <= set_hour;
            regs[`RTC_ADDR_MIN]  <= set_min;
            regs[`RTC_ADDR_SEC]  <= set_sec;
            seen_seq             <= set_seq;
        end
    end

    // Chip drives the bus only while the read strobe is low
    assign ad_in = (!pins.cs_n && pins.as_sel && !pins.rd_n) ? regs[addr_latch] : 8'h00;

    // Takes effect on the next clock edge
    task automatic set_time(input logic [7:0] hour, input logic [7:0] min,
                            input logic [7:0] sec);
        set_hour = hour;
        set_min  = min;
        set_sec  = sec;
        set_seq  = set_seq + 1;
    endtask

    function automatic logic [7:0] read_reg(input logic [7:0] addr);
        return regs[addr];
    endfunction

endmodule

`default_nettype wire

/* verification/rtc_controller_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rtc_defs.svh"

module rtc_controller_tb
    import rtc_bus_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int READY_BOUND  = 200;
    localparam int STEP_CYCLES  = 300;
    localparam int NUM_STEPS    = 26;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_WAIT_READY,
        OP_SET_TIME,
        OP_CHECK_REG,
        OP_CHECK_PINS,
        OP_IDLE
    } op_e;

    // One table entry
    typedef struct packed {
        op_e         op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] expected;
        logic        exp_err;
    } step_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    rtc_pins_t   rtc_pins;
    logic [7:0]  rtc_ad_in;

    step_t steps [NUM_STEPS];
    int    errors = 0;
    int    checks = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rtc_controller_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .rtc_pins  (rtc_pins),
        .rtc_ad_in (rtc_ad_in)
    );

    rtc_chip_model model_i (
        .clk   (clk),
        .pins  (rtc_pins),
        .ad_in (rtc_ad_in)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////
    function automatic void build_table();
        steps[0]  = '{OP_READ, `RTC_APB_STATUS, 32'h0, 32'h0, 1'b0};
        steps[1]  = '{OP_READ, `RTC_APB_TIME, 32'h0, 32'h0, 1'b0};
        // Strobes idle and bus released
        steps[2]  = '{OP_CHECK_PINS, 8'h00, 32'h0, 32'hE, 1'b0};
        steps[3]  = '{OP_WRITE, `RTC_APB_CTRL, 32'h1, 32'h0, 1'b0};
        steps[4]  = '{OP_WAIT_READY, 8'h00, 32'h0, 32'h0, 1'b0};
        // Setup writes in the order the chip needs them
        steps[5]  = '{OP_CHECK_REG, 8'h02, 32'h0, 32'h00, 1'b0};
        steps[6]  = '{OP_CHECK_REG, 8'h01, 32'h0, 32'h44, 1'b0};
        steps[7]  = '{OP_CHECK_REG, 8'h00, 32'h0, 32'h08, 1'b0};
        steps[8]  = '{OP_CHECK_REG, 8'h23, 32'h0, 32'h0C, 1'b0};
        steps[9]  = '{OP_IDLE, 8'h00, 32'd300, 32'h0, 1'b0};
        steps[10] = '{OP_READ, `RTC_APB_TIME, 32'h0, 32'h000C1530, 1'b0};
        steps[11] = '{OP_SET_TIME, 8'h00, 32'h000C5907, 32'h0, 1'b0};
        steps[12] = '{OP_IDLE, 8'h00, 32'd300, 32'h0, 1'b0};
        steps[13] = '{OP_READ, `RTC_APB_TIME, 32'h0, 32'h000C5907, 1'b0};
        // Unmapped offset
        steps[14] = '{OP_READ, 8'h0C, 32'h0, 32'h0, 1'b1};
        steps[15] = '{OP_WRITE, 8'h0C, 32'h0, 32'h0, 1'b1};
        steps[16] = '{OP_READ, `RTC_APB_CTRL, 32'h0, 32'h1, 1'b0};
        // Abort, clobber the hour, then init again
        steps[17] = '{OP_WRITE, `RTC_APB_CTRL, 32'h0, 32'h0, 1'b0};
        steps[18] = '{OP_READ, `RTC_APB_STATUS, 32'h0, 32'h0, 1'b0};
        steps[19] = '{OP_CHECK_PINS, 8'h00, 32'h0, 32'hE, 1'b0};
        steps[20] = '{OP_SET_TIME, 8'h00, 32'h00005907, 32'h0, 1'b0};
        steps[21] = '{OP_CHECK_REG, 8'h23, 32'h0, 32'h00, 1'b0};
        steps[22] = '{OP_WRITE, `RTC_APB_CTRL, 32'h1, 32'h0, 1'b0};
        steps[23] = '{OP_WAIT_READY, 8'h00, 32'h0, 32'h0, 1'b0};
        steps[24] = '{OP_CHECK_REG, 8'h23, 32'h0, 32'h0C, 1'b0};
        steps[25] = '{OP_READ, `RTC_APB_STATUS, 32'h0, 32'h1, 1'b0};
    endfunction

    function automatic string op_text(input op_e op);
        case (op)
            OP_WRITE:      return "apb write";
            OP_READ:       return "apb read";
            OP_WAIT_READY: return "wait ready";
            OP_SET_TIME:   return "set model time";
            OP_CHECK_REG:  return "model register";
            OP_CHECK_PINS: return "chip pins";
            default:       return "idle";
        endcase
    endfunction

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////////////////////////////
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waits;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // Sample mid-cycle once the slave is ready
        @(negedge clk);
        waits = 0;
        while (!pready && waits < 16) begin
            @(negedge clk);
            waits++;
        end
        assert (pready) else begin
            errors++;
            $display("APB slave never raised pready for address 0x%0h", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Each STATUS poll takes three clock cycles
    task automatic wait_ready(output logic seen);
        logic [31:0] status;
        logic        err;
        int          cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < READY_BOUND) begin
            apb_transfer(1'b0, `RTC_APB_STATUS, 32'h0, status, err);
            seen   = status[0];
            cycles = cycles + 3;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        step_t       s;
        int          errors_before;
        logic [31:0] rd;
        logic        err;
        logic        seen;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = 32'h0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < NUM_STEPS; i++) begin
            s             = steps[i];
            errors_before = errors;
            case (s.op)
                OP_WRITE: begin
                    apb_transfer(1'b1, s.addr, s.data, rd, err);
                    expect_equal("pslverr", 32'(err), 32'(s.exp_err));
                end
                OP_READ: begin
                    apb_transfer(1'b0, s.addr, 32'h0, rd, err);
                    expect_equal("prdata", rd, s.expected);
                    expect_equal("pslverr", 32'(err), 32'(s.exp_err));
                end
                OP_WAIT_READY: begin
                    wait_ready(seen);
                    checks++;
                    assert (seen) else begin
                        errors++;
                        $display("Ready did not rise within %0d cycles", READY_BOUND);
                    end
                end
                OP_SET_TIME: begin
                    model_i.set_time(s.data[23:16], s.data[15:8], s.data[7:0]);
                    @(posedge clk);
                    #1;
                end
                OP_CHECK_REG: begin
                    expect_equal("chip register", {24'h0, model_i.read_reg(s.addr)},
                                 s.expected);
                end
                OP_CHECK_PINS: begin
                    // cs_n, rd_n, wr_n and ad_oe
                    expect_equal("chip strobes",
                                 32'({rtc_pins.cs_n, rtc_pins.rd_n, rtc_pins.wr_n,
                                      rtc_pins.ad_oe}),
                                 s.expected);
                end
                default: begin
                    repeat (s.data) @(posedge clk);
                    #1;
                end
            endcase
            $display("test %0d (%s): %s", i, op_text(s.op),
                     (errors == errors_before) ? "pass" : "fail");
        end

        $display("%0d tests, %0d checks, %0d errors", NUM_STEPS, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(NUM_STEPS * STEP_CYCLES * CLK_PERIOD);
        $display("Run did not finish within %0d cycles", NUM_STEPS * STEP_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
